// File: dv/soc_bus_tb.sv
`timescale 1ns/1ps

module soc_bus_tb;
    import bus_pkg::*;
    import plic_pkg::*;

    logic       CLOCK_50;
    logic       KEY0;
    bus_req_t   req;
    data_t      mtime;
    logic [7:0] ascii;
    logic       irq;
    data_t      bus_read_data;
    logic       bus_read_done;
    logic       bus_write_done;
    logic       meip;
    logic       msip;

    logic [31:0]       ram_model [ram_words];
    data_t             mtimecmp_model;
    logic [prio_w-1:0] prio_model [plic_sources];
    logic [31:0]       enable_model [plic_contexts];
    logic [prio_w-1:0] thresh_model [plic_contexts];
    logic              pend_model;          // pending bit of the irq source
    data_t             expect_q [$];        // one entry per read in flight
    int                seed = 32'h7bfe;
    int                errors = 0;
    int                timeouts = 0;
    int                checks = 0;
    bit                finished = 1'b0;
    logic              rd_done_q = 1'b1;

    tb_clock clk_gen (.CLOCK_50(CLOCK_50));
    soc_bus uut (.*);

    // expected read data from the model state
    function automatic data_t expected_read(addr_t a, ls_type_t t);
        addr_t off;
        int    w;
        off = a - plic_base;
        w   = int'((a - ram_base) >> 2);
        if (a >= ram_base && a < ram_base + ram_words * 4) begin
            if (t == ls_d)
                return {ram_model[(w + 1) % ram_words], ram_model[w]};
            return {32'd0, ram_model[w] >> (8 * a[1:0])};   // zero filled, no sign
        end
        if (a == key_addr)
            return {56'd0, ascii};
        if (a == mtime_addr)
            return mtime;
        if (a == mtimecmp_addr)
            return mtimecmp_model;
        if (a >= plic_base && off < threshold_off + plic_contexts * context_stride) begin
            if (off < plic_sources * 4)
                return data_t'(prio_model[off[4:2]]);
            if (off == pending_off)
                return data_t'(pend_model) << irq_src_id;
            for (int c = 0; c < plic_contexts; c++) begin
                if (off == enable_off + c * enable_stride)
                    return data_t'(enable_model[c]);
                if (off == threshold_off + c * context_stride)
                    return data_t'(thresh_model[c]);
                if (off == claim_off + c * context_stride && pend_model
                        && enable_model[c][irq_src_id])
                    return data_t'(irq_src_id);
            end
        end
        return '0;   // unmapped and holes
    endfunction

    task automatic wait_done(bit wr);
        int n;
        n = 0;
        while ((wr ? !bus_write_done : !bus_read_done) && n < 20) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (wr ? !bus_write_done : !bus_read_done) begin
            $display("timeout: %s done did not return within 20 cycles", wr ? "write" : "read");
            timeouts++;
        end
    endtask

    task automatic bus_write(addr_t a, ls_type_t t, data_t d);
        addr_t off;
        int    w;
        off = a - plic_base;
        w   = int'((a - ram_base) >> 2);
        if (a >= ram_base && a < ram_base + ram_words * 4) begin
            case (t)
                ls_b: ram_model[w][8 * a[1:0] +: 8] = d[7:0];
                ls_h: ram_model[w][16 * a[1] +: 16] = d[15:0];   // aligned half
                ls_w: ram_model[w] = d[31:0];
                default: begin
                    ram_model[w] = d[31:0];
                    ram_model[(w + 1) % ram_words] = d[63:32];
                end
            endcase
        end
        if (a == mtimecmp_addr)
            mtimecmp_model = d;
        if (off < plic_sources * 4)
            prio_model[off[4:2]] = d[prio_w-1:0];
        for (int c = 0; c < plic_contexts; c++) begin
            if (off == enable_off + c * enable_stride)
                enable_model[c] = d[31:0];
            if (off == threshold_off + c * context_stride)
                thresh_model[c] = d[prio_w-1:0];
        end
        @(posedge CLOCK_50);
        #10;
        req.address = a;
        req.ls_type = t;
        req.wdata   = d;
        req.wr_en   = 1'b1;
        @(posedge CLOCK_50);
        #10;
        req.wr_en = 1'b0;
        wait_done(1'b1);
    endtask

    task automatic bus_read(addr_t a, ls_type_t t);
        expect_q.push_back(expected_read(a, t));
        for (int c = 0; c < plic_contexts; c++) begin
            if (a == plic_base + claim_off + c * context_stride && enable_model[c][irq_src_id])
                pend_model = 1'b0;   // claim completes the interrupt
        end
        @(posedge CLOCK_50);
        #10;
        req.address = a;
        req.ls_type = t;
        req.rd_en   = 1'b1;
        @(posedge CLOCK_50);
        #10;
        req.rd_en = 1'b0;
        wait_done(1'b0);
    endtask

    task automatic check_level(string what, logic got, logic want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic pulse_irq(int ctx);
        int n;
        @(posedge CLOCK_50);
        #10;
        irq        = 1'b1;
        pend_model = 1'b1;
        n = 0;
        while (!(ctx == 0 ? meip : msip) && n < 20) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (!(ctx == 0 ? meip : msip)) begin
            $display("timeout: interrupt output of context %0d never rose", ctx);
            timeouts++;
        end
        @(posedge CLOCK_50);
        #10;
        irq = 1'b0;
    endtask

    // done rising means a read finished
    always @(negedge CLOCK_50) begin
        data_t want;
        if (bus_read_done && !rd_done_q && expect_q.size() > 0) begin
            want = expect_q.pop_front();
            checks++;
            assert (bus_read_data === want) else begin
                errors++;
                $display("** Error at %0t: read of %h gave %h, expected %h",
                         $time, req.address, bus_read_data, want);
            end
        end
        rd_done_q = bus_read_done;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (!finished && timeouts == 0 && cycles < 20000) begin
            @(posedge CLOCK_50);
            cycles++;
        end
        if (!finished && timeouts == 0)
            $display("run stopped after %0d cycles before the sequence ended", cycles);
        $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (finished && errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        int    idx;
        int    n;
        addr_t a;
        data_t d;
        KEY0           = 1'b0;
        req            = '0;
        mtime          = '0;
        ascii          = '0;
        irq            = 1'b0;
        mtimecmp_model = mtimecmp_reset;
        pend_model     = 1'b0;
        for (int i = 0; i < plic_sources; i++)
            prio_model[i] = '0;
        for (int c = 0; c < plic_contexts; c++) begin
            enable_model[c] = '0;
            thresh_model[c] = '0;
        end
        repeat (5) @(posedge CLOCK_50);
        #10;
        KEY0 = 1'b1;

        check_level("bus_read_done", bus_read_done, 1'b1);
        check_level("bus_write_done", bus_write_done, 1'b1);
        check_level("meip", meip, 1'b0);
        check_level("msip", msip, 1'b0);
        bus_read(mtimecmp_addr, ls_d);

        // sw, sh, sb into one word, then every load type at every offset
        for (int i = 0; i < 6; i++) begin
            idx = $unsigned($random(seed)) % ram_words;
            a   = ram_base + idx * 4;
            bus_write(a, ls_w, data_t'($random(seed)));
            bus_write(a + $unsigned($random(seed)) % 4, ls_h, data_t'($random(seed)));
            bus_write(a + $unsigned($random(seed)) % 4, ls_b, data_t'($random(seed)));
            for (int t = 0; t < 7; t++) begin
                if (t == int'(ls_d))
                    continue;
                for (int o = 0; o < 4; o++)
                    bus_read(a + o, ls_type_t'(t));
            end
        end

        idx = $unsigned($random(seed)) % (ram_words - 1);
        a   = ram_base + idx * 4;
        d   = {$random(seed), $random(seed)};
        bus_write(a, ls_d, d);
        bus_read(a, ls_d);
        bus_read(a, ls_w);
        bus_read(a + 4, ls_w);

        d = {$random(seed), $random(seed)};
        bus_write(mtimecmp_addr, ls_d, d);
        bus_read(mtimecmp_addr, ls_d);
        @(posedge CLOCK_50);
        #10;
        mtime = {$random(seed), $random(seed)};
        ascii = d[15:8];
        bus_read(mtime_addr, ls_d);
        bus_read(key_addr, ls_bu);
        bus_write(64'h4000_0000, ls_w, d);   // nobody claims this window
        bus_read(64'h4000_0000, ls_d);

        for (int p = 0; p < plic_sources; p++) begin
            bus_write(plic_base + p * 4, ls_w, data_t'($random(seed)));
            bus_read(plic_base + p * 4, ls_w);
        end
        for (int c = 0; c < plic_contexts; c++) begin
            a = plic_base + enable_off + c * enable_stride;
            bus_write(a, ls_w, data_t'($random(seed)));
            bus_read(a, ls_w);
            a = plic_base + threshold_off + c * context_stride;
            bus_write(a, ls_w, data_t'($random(seed)));
            bus_read(a, ls_w);
        end

        // one irq edge per context with only that context enabled
        for (int c = 0; c < plic_contexts; c++) begin
            bus_write(plic_base + enable_off + c * enable_stride, ls_w, data_t'(1) << irq_src_id);
            bus_write(plic_base + enable_off + (1 - c) * enable_stride, ls_w, '0);
            pulse_irq(c);
            check_level(c == 0 ? "meip" : "msip", c == 0 ? meip : msip, 1'b1);
            check_level(c == 0 ? "msip" : "meip", c == 0 ? msip : meip, 1'b0);
            bus_read(plic_base + pending_off, ls_w);
            a = plic_base + claim_off + c * context_stride;
            bus_write(a, ls_w, 64'h1);
            bus_read(a, ls_w);
            check_level(c == 0 ? "meip" : "msip", c == 0 ? meip : msip, 1'b0);
        end

        n = 0;
        while (expect_q.size() > 0 && n < 10) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (expect_q.size() > 0) begin
            $display("%0d read results never arrived", expect_q.size());
            timeouts++;
        end
        finished = 1'b1;
    end

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic CLOCK_50
);
    localparam int half_period = 50;   // 100 ns period

    initial begin
        CLOCK_50 = 1'b0;
        forever #(half_period) CLOCK_50 = ~CLOCK_50;
    end

endmodule

// File: files.f
logic/bus_pkg.sv
logic/plic_pkg.sv
logic/addr_decode.sv
logic/word_ram.sv
logic/plic.sv
logic/bus_sequencer.sv
logic/soc_bus.sv
dv/tb_clock.sv
dv/soc_bus_tb.sv

// File: logic/addr_decode.sv
`timescale 1ns/1ps

module addr_decode (
    input  bus_pkg::addr_t      address,
    output bus_pkg::slave_sel_t sel
);
    import bus_pkg::*;
    import plic_pkg::*;

    addr_t ram_top;
    addr_t plic_top;

    assign ram_top  = ram_base + ram_words * 4;
    // window ends after the threshold/claim pair of the last context
    assign plic_top = plic_base + threshold_off + plic_contexts * context_stride;

    always_comb begin
        sel          = '0;
        sel.ram      = (address >= ram_base) && (address < ram_top);
        sel.key      = (address == key_addr);
        sel.mtime    = (address == mtime_addr);
        sel.mtimecmp = (address == mtimecmp_addr);
        sel.plic     = (address >= plic_base) && (address < plic_top);
    end

endmodule

// File: logic/bus_pkg.sv
package bus_pkg;

    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;

    // load encodings, stores reuse 0..3 for sb/sh/sw/sd
    typedef enum logic [2:0] {
        ls_b  = 3'd0,
        ls_h  = 3'd1,
        ls_w  = 3'd2,
        ls_d  = 3'd3,
        ls_bu = 3'd4,
        ls_hu = 3'd5,
        ls_wu = 3'd6
    } ls_type_t;

    // address map
    localparam addr_t ram_base       = 64'h8000_0000;
    localparam int    ram_words      = 1024;
    localparam int    ram_addr_w     = 10;       // word index width
    localparam addr_t key_addr       = 64'h1000_0000;
    localparam addr_t mtime_addr     = 64'h0200_BFF8;
    localparam addr_t mtimecmp_addr  = 64'h0200_4000;
    localparam data_t mtimecmp_reset = 64'h8000_0000;
    localparam addr_t plic_base      = 64'h0C00_0000;

    // master side of the bus, held stable until the matching done
    typedef struct packed {
        addr_t    address;
        data_t    wdata;
        ls_type_t ls_type;
        logic     rd_en;     // one-cycle read strobe
        logic     wr_en;     // one-cycle write strobe
    } bus_req_t;

    // one bit per slave, all zero when nobody claims the address
    typedef struct packed {
        logic ram;
        logic key;
        logic mtime;
        logic mtimecmp;
        logic plic;
    } slave_sel_t;

endpackage

// File: logic/bus_sequencer.sv
`timescale 1ns/1ps

module bus_sequencer (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  bus_pkg::bus_req_t   req,
    input  bus_pkg::slave_sel_t sel,
    input  bus_pkg::data_t      mtime,
    input  logic [7:0]          ascii,
    input  bus_pkg::data_t      ram_rdata,
    input  bus_pkg::data_t      plic_rdata,
    input  logic                ram_ack,
    input  logic                plic_ack,
    output logic                rd_active,
    output logic                wr_active,
    output bus_pkg::data_t      bus_read_data,
    output logic                bus_read_done,
    output logic                bus_write_done
);
    import bus_pkg::*;

    data_t mtimecmp;
    data_t rd_data;
    logic  rd_ack;
    logic  wr_ack;

    assign rd_active = !bus_read_done;
    assign wr_active = !bus_write_done;

    // local registers answer at once, unmapped reads give zero
    always_comb begin
        rd_data = '0;
        rd_ack  = 1'b1;
        if (sel.ram) begin
            rd_data = ram_rdata;
            rd_ack  = ram_ack;
        end else if (sel.plic) begin
            rd_data = plic_rdata;
            rd_ack  = plic_ack;
        end else if (sel.key) begin
            rd_data = {56'd0, ascii};
        end else if (sel.mtime) begin
            rd_data = mtime;
        end else if (sel.mtimecmp) begin
            rd_data = mtimecmp;
        end
    end

    always_comb begin
        wr_ack = 1'b1;   // key, mtime and holes swallow writes
        if (sel.ram) begin
            wr_ack = ram_ack;
        end else if (sel.plic) begin
            wr_ack = plic_ack;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            mtimecmp       <= mtimecmp_reset;
        end else begin
            if (req.rd_en) begin
                bus_read_done <= 1'b0;
            end
            if (req.wr_en) begin
                bus_write_done <= 1'b0;
            end
            if (rd_active && rd_ack) begin
                bus_read_done <= 1'b1;
            end
            if (wr_active && wr_ack) begin
                bus_write_done <= 1'b1;
                if (sel.mtimecmp) begin
                    mtimecmp <= req.wdata;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rd_active && rd_ack) begin
            bus_read_data <= rd_data;
        end
    end

    a_rd_strobe: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        req.rd_en |-> bus_read_done)
        else $error("read strobe while a read is still in flight");

    a_wr_strobe: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        req.wr_en |-> bus_write_done)
        else $error("write strobe while a write is still in flight");

endmodule

// File: logic/plic.sv
`timescale 1ns/1ps

module plic (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  bus_pkg::bus_req_t req,
    input  logic              sel_plic,
    input  logic              rd_active,
    input  logic              wr_active,
    input  logic              irq,
    output bus_pkg::data_t    rdata,
    output logic              ack,
    output logic              meip,
    output logic              msip
);
    import bus_pkg::*;
    import plic_pkg::*;

    addr_t                           off;
    logic [$clog2(plic_sources)-1:0] prio_idx;
    logic                            prio_hit;
    logic                            pend_hit;
    logic [plic_contexts-1:0]        en_hit;
    logic [plic_contexts-1:0]        th_hit;
    logic [plic_contexts-1:0]        cl_hit;
    logic [plic_contexts-1:0]        claim_on;   // claim value is irq_src_id
    logic [prio_w-1:0]               prio [plic_sources];
    logic [31:0]                     pending;
    plic_ctx_t                       ctx [plic_contexts];
    logic                            irq_q;
    logic                            rd_go;
    logic                            wr_go;

    assign off      = req.address - plic_base;
    assign prio_idx = off[2 +: $clog2(plic_sources)];
    assign prio_hit = off < plic_sources * 4;       // 4 bytes per id
    assign pend_hit = off == pending_off;

    assign rd_go = sel_plic && rd_active;
    assign wr_go = sel_plic && wr_active;
    assign ack   = rd_go || wr_go;                 // every register answers at once

    always_comb begin
        for (int c = 0; c < plic_contexts; c++) begin
            en_hit[c]   = off == enable_off + c * enable_stride;
            th_hit[c]   = off == threshold_off + c * context_stride;
            cl_hit[c]   = off == claim_off + c * context_stride;
            claim_on[c] = pending[irq_src_id] && ctx[c].enable[irq_src_id];
        end
    end

    assign meip = claim_on[0];
    assign msip = claim_on[1];

    always_comb begin
        rdata = '0;   // holes in the window read as zero
        if (prio_hit) begin
            rdata = data_t'(prio[prio_idx]);
        end
        if (pend_hit) begin
            rdata = data_t'(pending);
        end
        for (int c = 0; c < plic_contexts; c++) begin
            if (en_hit[c]) begin
                rdata = data_t'(ctx[c].enable);
            end
            if (th_hit[c]) begin
                rdata = data_t'(ctx[c].threshold);
            end
            if (cl_hit[c] && claim_on[c]) begin
                rdata = data_t'(irq_src_id);
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_q   <= 1'b0;
            pending <= '0;
            for (int i = 0; i < plic_sources; i++) begin
                prio[i] <= '0;
            end
            for (int c = 0; c < plic_contexts; c++) begin
                ctx[c] <= '0;
            end
        end else begin
            irq_q <= irq;
            if (wr_go && prio_hit) begin
                prio[prio_idx] <= req.wdata[prio_w-1:0];
            end
            for (int c = 0; c < plic_contexts; c++) begin
                if (wr_go && en_hit[c]) begin
                    ctx[c].enable <= req.wdata[31:0];
                end
                if (wr_go && th_hit[c]) begin
                    ctx[c].threshold <= req.wdata[prio_w-1:0];
                end
                if (rd_go && cl_hit[c] && claim_on[c]) begin
                    pending[irq_src_id] <= 1'b0;   // claim read completes the interrupt
                end
            end
            // a fresh edge beats a claim in the same cycle
            if (irq && !irq_q) begin
                pending[irq_src_id] <= 1'b1;
            end
        end
    end

    a_meip_pending: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        meip |-> pending[irq_src_id]);

endmodule

// File: logic/plic_pkg.sv
package plic_pkg;

    localparam int plic_sources  = 6;    // priority entries
    localparam int plic_contexts = 2;    // ctx0 machine, ctx1 supervisor
    localparam int prio_w        = 3;

    // offsets from plic_base
    localparam logic [31:0] pending_off    = 32'h0000_1000;
    localparam logic [31:0] enable_off     = 32'h0000_2000;
    localparam logic [31:0] enable_stride  = 32'h0000_0080;
    localparam logic [31:0] threshold_off  = 32'h0020_0000;
    localparam logic [31:0] claim_off      = 32'h0020_0004;
    localparam logic [31:0] context_stride = 32'h0000_1000;

    // source driven by the external irq line
    localparam int irq_src_id = 1;

    // per-context state
    typedef struct packed {
        logic [31:0]       enable;
        logic [prio_w-1:0] threshold;   // stored only, claims ignore it
    } plic_ctx_t;

endpackage

// File: logic/soc_bus.sv
`timescale 1ns/1ps

module soc_bus (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  bus_pkg::bus_req_t req,
    input  bus_pkg::data_t    mtime,
    input  logic [7:0]        ascii,
    input  logic              irq,
    output bus_pkg::data_t    bus_read_data,
    output logic              bus_read_done,
    output logic              bus_write_done,
    output logic              meip,
    output logic              msip
);
    import bus_pkg::*;

    slave_sel_t sel;
    data_t      ram_rdata;
    data_t      plic_rdata;
    logic       ram_ack;
    logic       plic_ack;
    logic       rd_active;   // read in progress
    logic       wr_active;   // write in progress

    addr_decode u_decode (
        .address (req.address),
        .sel     (sel)
    );

    bus_sequencer u_seq (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .req            (req),
        .sel            (sel),
        .mtime          (mtime),
        .ascii          (ascii),
        .ram_rdata      (ram_rdata),
        .plic_rdata     (plic_rdata),
        .ram_ack        (ram_ack),
        .plic_ack       (plic_ack),
        .rd_active      (rd_active),
        .wr_active      (wr_active),
        .bus_read_data  (bus_read_data),
        .bus_read_done  (bus_read_done),
        .bus_write_done (bus_write_done)
    );

    word_ram u_ram (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .req       (req),
        .sel_ram   (sel.ram),
        .rd_active (rd_active),
        .wr_active (wr_active),
        .rdata     (ram_rdata),
        .ack       (ram_ack)
    );

    plic u_plic (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .req       (req),
        .sel_plic  (sel.plic),
        .rd_active (rd_active),
        .wr_active (wr_active),
        .irq       (irq),
        .rdata     (plic_rdata),
        .ack       (plic_ack),
        .meip      (meip),
        .msip      (msip)
    );

endmodule

// File: logic/word_ram.sv
`timescale 1ns/1ps

module word_ram (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  bus_pkg::bus_req_t req,
    input  logic              sel_ram,
    input  logic              rd_active,
    input  logic              wr_active,
    output bus_pkg::data_t    rdata,
    output logic              ack
);
    import bus_pkg::*;

    logic [31:0]           mem [ram_words];
    logic [ram_addr_w-1:0] idx;
    logic [ram_addr_w-1:0] idx_next;
    logic [1:0]            boff;
    logic                  is_dbl;
    logic                  rd_go;
    logic                  wr_go;
    logic                  busy;
    logic                  step;      // 1 while on the high word of ld/sd
    logic [31:0]           lo_word;   // low half of an ld

    assign idx      = req.address[2 +: ram_addr_w];
    assign idx_next = idx + 1'b1;     // wraps inside the window
    assign boff     = req.address[1:0];
    assign is_dbl   = (req.ls_type == ls_d);

    assign rd_go = sel_ram && rd_active;
    assign wr_go = sel_ram && wr_active;
    assign busy  = rd_go || wr_go;

    // doubles answer on their second step only
    assign ack = busy && (!is_dbl || step);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            step <= 1'b0;
        end else if (busy && is_dbl) begin
            step <= ~step;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rd_go && is_dbl && !step) begin
            lo_word <= mem[idx];
        end
    end

    // sub-word loads hand back the shifted word, no masking or sign fill
    always_comb begin
        if (is_dbl) begin
            rdata = {mem[idx_next], lo_word};
        end else begin
            rdata = {32'd0, mem[idx] >> {boff, 3'b000}};
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (wr_go) begin
            case (req.ls_type)
                ls_b: begin
                    mem[idx][{boff, 3'b000} +: 8] <= req.wdata[7:0];
                end
                ls_h: begin
                    mem[idx][{boff[1], 4'b0000} +: 16] <= req.wdata[15:0];   // aligned half
                end
                ls_w: begin
                    mem[idx] <= req.wdata[31:0];
                end
                ls_d: begin
                    if (!step) begin
                        mem[idx] <= req.wdata[31:0];
                    end else begin
                        mem[idx_next] <= req.wdata[63:32];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // the master only issues sb/sh/sw/sd codes for stores
    a_store_type: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        wr_go |-> req.ls_type inside {ls_b, ls_h, ls_w, ls_d})
        else $error("store into RAM with load-only ls_type %0d", req.ls_type);

    // an ld/sd always gets its second step on the following cycle
    a_dbl_second: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (busy && is_dbl && !step) |=> (busy && step && ack));

endmodule

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal --top-module soc_bus_tb -f files.f \
    -o soc_bus_sim \
    && ./obj_dir/soc_bus_sim | tee /dev/stderr | grep "^Test OK$" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
